// ==== hw/mailbox_defines.svh ====
/*
 * MMC mailbox constants
 * Snoop locations, expected build hash, receive enable default
 * and the UDP port table defaults
 */
`ifndef MAILBOX_DEFINES_SVH
`define MAILBOX_DEFINES_SVH

// Mailbox addressing, page select on top of the SPI index
`define MAILBOX_PAGE_W 7
`define MAILBOX_OFFSET_W 4
`define MAILBOX_ADDR_W (`MAILBOX_PAGE_W + `MAILBOX_OFFSET_W)

// Snooped locations, four bytes each, MSB at the offset
`define MAILBOX_GITID_PAGE 3
`define MAILBOX_GITID_OFFSET 12
`define MAILBOX_HASH_PAGE 4
`define MAILBOX_HASH_OFFSET 12

`define MAILBOX_HASH 32'h5a17c3e9 // Expected build hash
`define MAILBOX_DEFAULT_ENABLE_RX 1'b1

// UDP port numbers loaded at reset
`define MAILBOX_UDP_PORT0 16'd7
`define MAILBOX_UDP_PORT1 16'd801
`define MAILBOX_UDP_PORT2 16'd802
`define MAILBOX_UDP_PORT3 16'd803
`define MAILBOX_UDP_PORT4 16'd0
`define MAILBOX_UDP_PORT5 16'd0
`define MAILBOX_UDP_PORT6 16'd0
`define MAILBOX_UDP_PORT7 16'd0

`endif

// ==== hw/mailbox_pkg.sv ====
/*
 * MMC mailbox types
 * SPI word layout, config strobe bus and command encodings
 */
`default_nettype none

package mailbox_pkg;

  // Command and mailbox view of a word
  typedef struct packed {
    logic [3:0] opcode;
    logic [3:0] index;
    logic [7:0] data;
  } spi_fields_t;

  // Port table view, index split into slot and byte select
  typedef struct packed {
    logic [3:0] opcode;
    logic [2:0] slot;
    logic       hi_byte; // 1 selects bits 15:8 of the entry
    logic [7:0] data;
  } spi_port_t;

  typedef union packed {
    spi_fields_t fields;
    spi_port_t   port;
  } spi_word_u;

  typedef struct packed {
    logic      wr;   // Full word received
    logic      rd;   // First byte of a read received
    spi_word_u word; // Only opcode/index valid on rd
  } cfg_bus_t;

  localparam logic [3:0] OP_IPMAC    = 4'd1;
  localparam logic [3:0] OP_SPECIAL  = 4'd2;
  localparam logic [3:0] OP_PORT     = 4'd3;
  localparam logic [3:0] OP_MB_READ  = 4'd4;
  localparam logic [3:0] OP_MB_WRITE = 4'd5;

  // Index values under OP_SPECIAL
  localparam logic [3:0] SPECIAL_ENABLE = 4'd0;
  localparam logic [3:0] SPECIAL_PAGE   = 4'd2;

endpackage

`default_nettype wire

// ==== hw/spi_responder.sv ====
/*
 * Pseudo-SPI responder
 * Oversamples sck/ncs/pico in clk, assembles 16-bit words,
 * issues an early read strobe after the first byte and a write
 * strobe at the end of a complete frame, returns a byte on poci
 */
`timescale 1ns/10ps
`default_nettype none

module spi_responder (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  sck,
  input  logic                  ncs,
  input  logic                  pico,
  input  logic [7:0]            reply,
  output logic                  poci,
  output mailbox_pkg::cfg_bus_t cfg
);
  import mailbox_pkg::*;

  logic [2:0]  sck_q;    // [1] is synchronized, [2] is previous
  logic [2:0]  ncs_q;
  logic [1:0]  pico_q;
  logic        sck_rise;
  logic        sck_fall;
  logic        ncs_rise;
  logic        ncs_fall;
  logic [15:0] rx_sr;
  logic [4:0]  bit_cnt;  // Saturates, so long frames never look complete
  logic [1:0]  rd_dly;
  logic [1:0]  wr_dly;
  logic        load_q;
  logic [7:0]  tx_sr;
  spi_word_u   head;     // First byte as a word, data zeroed

  // Two-flop synchronizer plus one for edge detect
  always_ff @(posedge clk) begin
    if (reset) begin
      sck_q  <= '0;
      ncs_q  <= '1; // Deselected, no false edge out of reset
      pico_q <= '0;
    end else begin
      sck_q  <= {sck_q[1:0], sck};
      ncs_q  <= {ncs_q[1:0], ncs};
      pico_q <= {pico_q[0], pico};
    end
  end

  assign sck_rise = sck_q[1] & ~sck_q[2] & ~ncs_q[1]; // Only inside a frame
  assign sck_fall = ~sck_q[1] & sck_q[2] & ~ncs_q[1];
  assign ncs_fall = ~ncs_q[1] & ncs_q[2];
  assign ncs_rise = ncs_q[1] & ~ncs_q[2];

  // Receive side, MSB first
  always_ff @(posedge clk) begin
    if (sck_rise)
      rx_sr <= {rx_sr[14:0], pico_q[1]};
  end

  always_ff @(posedge clk) begin
    if (reset)
      bit_cnt <= '0;
    else if (ncs_fall)
      bit_cnt <= '0; // New frame
    else if (sck_rise && bit_cnt != 5'd31)
      bit_cnt <= bit_cnt + 5'd1;
  end

  // Strobe pipelines, two stages plus the cfg register
  always_ff @(posedge clk) begin
    if (reset) begin
      rd_dly <= '0;
      wr_dly <= '0;
    end else begin
      rd_dly <= {rd_dly[0], sck_rise && bit_cnt == 5'd7}; // Eighth rise
      wr_dly <= {wr_dly[0], ncs_rise && bit_cnt == 5'd16};
    end
  end

  assign head = {rx_sr[7:0], 8'h00};

  always_ff @(posedge clk) begin
    cfg.wr <= wr_dly[1];
    cfg.rd <= rd_dly[1] && head.fields.opcode == OP_MB_READ;
    if (wr_dly[1])
      cfg.word <= rx_sr;
    else if (rd_dly[1])
      cfg.word <= head; // Opcode and index ahead of the data byte
    if (reset) begin
      cfg.wr <= 1'b0;
      cfg.rd <= 1'b0;
    end
  end

  // Transmit side, reply arrives the cycle after cfg.rd
  always_ff @(posedge clk) begin
    if (reset)
      load_q <= 1'b0;
    else
      load_q <= cfg.rd;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      tx_sr <= '0;
      poci  <= 1'b0;
    end else if (ncs_fall) begin
      tx_sr <= '0; // Zeros during the first byte
    end else if (ncs_rise) begin
      poci <= 1'b0;
    end else if (load_q) begin
      tx_sr <= reply; // Before the eighth falling edge
    end else if (sck_fall) begin
      poci  <= tx_sr[7];
      tx_sr <= {tx_sr[6:0], 1'b0};
    end
  end

endmodule

`default_nettype wire

// ==== hw/mailbox_cmd_decode.sv ====
/*
 * Mailbox command decoder
 * Turns config strobes into MAC/IP, receive enable, page select,
 * UDP port table and snooped git ID / build hash
 */
`timescale 1ns/10ps
`default_nettype none
`include "mailbox_defines.svh"

module mailbox_cmd_decode (
  input  logic                  clk,
  input  logic                  reset,
  input  mailbox_pkg::cfg_bus_t cfg,
  input  logic [2:0]            pno_a,
  output logic [6:0]            mb_page,
  output logic [10:0]           mb_addr,
  output logic                  mb_wen,
  output logic                  mb_ren,
  output logic                  mb_strobe,
  output logic                  config_s,
  output logic                  config_p,
  output logic                  enable_rx,
  output logic                  ip_valid,
  output logic [31:0]           ip,
  output logic                  mac_valid,
  output logic [47:0]           mac,
  output logic                  match,
  output logic [31:0]           mmc_gitid,
  output logic                  mmc_gitid_valid,
  output logic [15:0]           pno_d
);
  import mailbox_pkg::*;

  spi_word_u   word;
  logic        wr_ipmac;
  logic        wr_special;
  logic        wr_port;
  logic        wr_mb;
  logic [7:0]  ipmac [16];
  logic [15:0] ipmac_valid;    // One bit per latched byte
  logic [15:0] pno_mem [8];
  logic [31:0] snoop_val [2];  // 0 is git ID, 1 is hash
  logic [3:0]  snoop_vld [2];

  assign word = cfg.word;

  assign wr_ipmac   = cfg.wr && word.fields.opcode == OP_IPMAC;
  assign wr_special = cfg.wr && word.fields.opcode == OP_SPECIAL;
  assign wr_port    = cfg.wr && word.fields.opcode == OP_PORT;
  assign wr_mb      = cfg.wr && word.fields.opcode == OP_MB_WRITE;

  // Same-cycle strobes
  assign config_s  = wr_ipmac;
  assign config_p  = wr_port;
  assign mb_wen    = wr_mb;
  assign mb_ren    = cfg.rd && word.fields.opcode == OP_MB_READ;
  assign mb_strobe = cfg.wr;  // End of every complete frame
  assign mb_addr   = {mb_page, word.fields.index};

  // Receive enable and page select
  always_ff @(posedge clk) begin
    if (reset) begin
      enable_rx <= `MAILBOX_DEFAULT_ENABLE_RX;
      mb_page   <= '0;
    end else if (wr_special) begin
      case (word.fields.index)
        SPECIAL_ENABLE: enable_rx <= word.fields.data[0];
        SPECIAL_PAGE:   mb_page   <= word.fields.data[6:0];
        default: ;      // Other specials ignored
      endcase
    end
  end

  // IP/MAC bytes
  always_ff @(posedge clk) begin
    if (wr_ipmac)
      ipmac[word.fields.index] <= word.fields.data;
  end

  always_ff @(posedge clk) begin
    if (reset)
      ipmac_valid <= '0;
    else if (wr_ipmac) begin
      if (word.fields.index == 4'd0)
        ipmac_valid <= 16'h0001; // Byte 0 restarts the table
      else
        ipmac_valid[word.fields.index] <= 1'b1;
    end
  end

  assign mac_valid = &ipmac_valid[5:0];
  assign ip_valid  = &ipmac_valid[9:6];
  assign mac = {ipmac[5], ipmac[4], ipmac[3], ipmac[2], ipmac[1], ipmac[0]};
  assign ip  = {ipmac[9], ipmac[8], ipmac[7], ipmac[6]};

  // UDP port table, written a byte at a time
  always_ff @(posedge clk) begin
    if (reset) begin
      pno_mem[0] <= `MAILBOX_UDP_PORT0;
      pno_mem[1] <= `MAILBOX_UDP_PORT1;
      pno_mem[2] <= `MAILBOX_UDP_PORT2;
      pno_mem[3] <= `MAILBOX_UDP_PORT3;
      pno_mem[4] <= `MAILBOX_UDP_PORT4;
      pno_mem[5] <= `MAILBOX_UDP_PORT5;
      pno_mem[6] <= `MAILBOX_UDP_PORT6;
      pno_mem[7] <= `MAILBOX_UDP_PORT7;
    end else if (wr_port) begin
      if (word.port.hi_byte)
        pno_mem[word.port.slot][15:8] <= word.port.data;
      else
        pno_mem[word.port.slot][7:0] <= word.port.data;
    end
  end

  assign pno_d = pno_mem[pno_a];

  // Snoop mailbox writes; both checked, pages may coincide
  for (genvar i = 0; i < 2; i++) begin : g_snoop
    localparam int PAGE = (i == 0) ? `MAILBOX_GITID_PAGE : `MAILBOX_HASH_PAGE;
    localparam int OFFSET = (i == 0) ? `MAILBOX_GITID_OFFSET : `MAILBOX_HASH_OFFSET;

    logic       hit;
    logic [1:0] sel;  // 0 is the most significant byte

    assign hit = wr_mb && mb_page == 7'(PAGE)
                 && int'(word.fields.index) >= OFFSET
                 && int'(word.fields.index) < OFFSET + 4;
    assign sel = 2'(int'(word.fields.index) - OFFSET);

    always_ff @(posedge clk) begin
      if (hit)
        snoop_val[i][8*(3-sel) +: 8] <= word.fields.data;
    end

    always_ff @(posedge clk) begin
      if (reset)
        snoop_vld[i] <= '0;
      else if (hit) begin
        if (sel == 2'd0)
          snoop_vld[i] <= 4'b0001; // MSB write starts over
        else
          snoop_vld[i][sel] <= 1'b1;
      end
    end
  end

  assign mmc_gitid       = snoop_val[0];
  assign mmc_gitid_valid = &snoop_vld[0];
  assign match = (&snoop_vld[1]) && (snoop_val[1] == `MAILBOX_HASH);

endmodule

`default_nettype wire

// ==== hw/mailbox_dpram.sv ====
/*
 * Mailbox memory, 2 kB of bytes
 * Port 1 serves SPI page/index accesses, port 2 the local bus
 */
`timescale 1ns/10ps
`default_nettype none
`include "mailbox_defines.svh"

module mailbox_dpram (
  input  logic                        clk,
  input  logic                        reset,
  input  mailbox_pkg::cfg_bus_t       cfg,
  input  logic [`MAILBOX_PAGE_W-1:0]  mb_page,
  input  logic [10:0]                 lb_addr,
  input  logic [7:0]                  lb_din,
  input  logic                        lb_write,
  input  logic                        lb_strobe,
  output logic [7:0]                  reply,
  output logic [7:0]                  lb_dout
);
  import mailbox_pkg::*;

  logic [7:0]                 mem [2**`MAILBOX_ADDR_W];
  logic [`MAILBOX_ADDR_W-1:0] addr1;
  logic                       wen1;
  logic                       wen2;
  logic                       lb_ren;   // Strobe delayed one cycle
  logic [`MAILBOX_ADDR_W-1:0] lb_addr_q;

  assign addr1 = {mb_page, cfg.word.fields.index};
  assign wen1  = cfg.wr && cfg.word.fields.opcode == OP_MB_WRITE;
  assign wen2  = lb_write && !(wen1 && addr1 == lb_addr); // SPI wins a clash

  always_ff @(posedge clk) begin
    if (wen1)
      mem[addr1] <= cfg.word.fields.data;
    if (wen2)
      mem[lb_addr] <= lb_din;
  end

  // SPI read, data back to the responder next cycle
  always_ff @(posedge clk) begin
    if (cfg.rd)
      reply <= mem[addr1];
  end

  // Local bus read
  always_ff @(posedge clk) begin
    if (reset)
      lb_ren <= 1'b0;
    else
      lb_ren <= lb_strobe & ~lb_write;
  end

  always_ff @(posedge clk) begin
    lb_addr_q <= lb_addr;  // Address held with the strobe
    if (lb_ren)
      lb_dout <= mem[lb_addr_q];
  end

endmodule

`default_nettype wire

// ==== hw/mmc_mailbox.sv ====
/*
 * MMC mailbox, FPGA responder side
 * SPI responder, command decoder and mailbox memory
 */
`timescale 1ns/10ps
`default_nettype none

module mmc_mailbox (
  input  logic        clk,
  input  logic        reset,
  // SPI from the MMC
  input  logic        sck,
  input  logic        ncs,
  input  logic        pico,
  output logic        poci,
  // Local bus, 2 kB window
  input  logic [10:0] lb_addr,
  input  logic [7:0]  lb_din,
  input  logic        lb_write,
  input  logic        lb_strobe,
  output logic [7:0]  lb_dout,
  // Mailbox access status
  output logic [10:0] mb_addr,
  output logic        mb_wen,
  output logic        mb_ren,
  output logic        mb_strobe,
  output logic        config_s,
  output logic        config_p,
  // Port table lookup
  input  logic [2:0]  pno_a,
  output logic [15:0] pno_d,
  // Decoded values
  output logic        enable_rx,
  output logic        ip_valid,
  output logic [31:0] ip,
  output logic        mac_valid,
  output logic [47:0] mac,
  output logic        match,
  output logic [31:0] mmc_gitid,
  output logic        mmc_gitid_valid
);
  import mailbox_pkg::*;

  cfg_bus_t   cfg;
  logic [7:0] reply;    // Memory byte going back over SPI
  logic [6:0] mb_page;

  spi_responder i_spi_responder (
    .clk   (clk),
    .reset (reset),
    .sck   (sck),
    .ncs   (ncs),
    .pico  (pico),
    .reply (reply),
    .poci  (poci),
    .cfg   (cfg)
  );

  mailbox_cmd_decode i_cmd_decode (
    .clk             (clk),
    .reset           (reset),
    .cfg             (cfg),
    .pno_a           (pno_a),
    .mb_page         (mb_page),
    .mb_addr         (mb_addr),
    .mb_wen          (mb_wen),
    .mb_ren          (mb_ren),
    .mb_strobe       (mb_strobe),
    .config_s        (config_s),
    .config_p        (config_p),
    .enable_rx       (enable_rx),
    .ip_valid        (ip_valid),
    .ip              (ip),
    .mac_valid       (mac_valid),
    .mac             (mac),
    .match           (match),
    .mmc_gitid       (mmc_gitid),
    .mmc_gitid_valid (mmc_gitid_valid),
    .pno_d           (pno_d)
  );

  mailbox_dpram i_dpram (
    .clk       (clk),
    .reset     (reset),
    .cfg       (cfg),
    .mb_page   (mb_page),
    .lb_addr   (lb_addr),
    .lb_din    (lb_din),
    .lb_write  (lb_write),
    .lb_strobe (lb_strobe),
    .reply     (reply),
    .lb_dout   (lb_dout)
  );

endmodule

`default_nettype wire

// ==== test/mailbox_properties.sv ====
/*
 * Concurrent checks on the MMC mailbox
 * Strobe shape around reset, and match against a model of the
 * hash bytes seen on mailbox writes
 */
`timescale 1ns/10ps
`default_nettype none
`include "mailbox_defines.svh"

module mailbox_properties (
  input logic                  clk,
  input logic                  reset,
  input mailbox_pkg::cfg_bus_t cfg,
  input logic [10:0]           mb_addr,
  input logic                  mb_wen,
  input logic                  mb_ren,
  input logic                  mb_strobe,
  input logic                  config_s,
  input logic                  config_p,
  input logic                  match
);
  import mailbox_pkg::*;

  logic       hash_hit;   // Mailbox write into one of the hash bytes
  logic [1:0] hash_sel;   // 0 is the most significant byte
  logic [3:0] hash_seen;  // Bytes written since the last MSB write

  assign hash_hit = mb_wen && mb_addr[10:4] == 7'(`MAILBOX_HASH_PAGE)
                    && int'(mb_addr[3:0]) >= `MAILBOX_HASH_OFFSET
                    && int'(mb_addr[3:0]) < `MAILBOX_HASH_OFFSET + 4;
  assign hash_sel = 2'(int'(mb_addr[3:0]) - `MAILBOX_HASH_OFFSET);

  always_ff @(posedge clk) begin
    if (reset)
      hash_seen <= '0;
    else if (hash_hit) begin
      if (hash_sel == 2'd0)
        hash_seen <= 4'b0001; // MSB starts a new hash
      else
        hash_seen[hash_sel] <= 1'b1;
    end
  end

  // Registers settled by the previous reset edge
  a_reset_quiet: assert property (@(posedge clk)
    $past(reset) |-> !cfg.wr && !cfg.rd && !mb_strobe && !config_s && !config_p)
    else $error("strobe active while in reset");

  a_wr_pulse: assert property (@(posedge clk) disable iff (reset)
    cfg.wr |=> !cfg.wr)
    else $error("cfg.wr high for more than one cycle");

  a_rd_pulse: assert property (@(posedge clk) disable iff (reset)
    cfg.rd |=> !cfg.rd)
    else $error("cfg.rd high for more than one cycle");

  a_wen_ren: assert property (@(posedge clk) disable iff (reset)
    !(mb_wen && mb_ren))
    else $error("mailbox read and write strobes together");

  a_match_valid: assert property (@(posedge clk) disable iff (reset)
    match |-> &hash_seen)
    else $error("match without all four hash bytes written");

endmodule

bind mmc_mailbox mailbox_properties i_mailbox_properties (
  .clk       (clk),
  .reset     (reset),
  .cfg       (cfg),
  .mb_addr   (mb_addr),
  .mb_wen    (mb_wen),
  .mb_ren    (mb_ren),
  .mb_strobe (mb_strobe),
  .config_s  (config_s),
  .config_p  (config_p),
  .match     (match)
);

`default_nettype wire

// ==== test/tb_mmc_mailbox.sv ====
/*
 * Testbench for the MMC mailbox
 * SPI frames from a modelled MMC, local-bus cycles, and checks of the
 * decoded outputs against a model held in testbench arrays
 */
`timescale 1ns/10ps
`default_nettype none
`include "mailbox_defines.svh"

module tb_mmc_mailbox;
  import mailbox_pkg::*;

  localparam int HALF_BIT = 10;          // clk cycles per sck half period
  localparam int TIMEOUT_CYCLES = 60000; // About twice the ~70 frames of 361 cycles

  logic        clk = 1'b0;
  logic        reset, sck, ncs, pico, poci;
  logic [10:0] lb_addr, mb_addr;
  logic [7:0]  lb_din, lb_dout;
  logic        lb_write, lb_strobe;
  logic        mb_wen, mb_ren, mb_strobe, config_s, config_p;
  logic [2:0]  pno_a;
  logic [15:0] pno_d;
  logic        enable_rx, ip_valid, mac_valid, match, mmc_gitid_valid;
  logic [31:0] ip, mmc_gitid;
  logic [47:0] mac;

  logic [7:0]  ipmac_ref [16];  // IP/MAC bytes as written
  logic [15:0] pno_ref [8];     // Port table model
  logic [10:0] last_mb_addr = '0;
  int          cycles = 0;
  int          wr_pulses = 0;
  int          s_pulses = 0;
  int          p_pulses = 0;

  mmc_mailbox i_mmc_mailbox (.*);

  always #20 clk = ~clk; // 40 ns period

  // Strobe counters, address capture and the run limit
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (mb_strobe) wr_pulses <= wr_pulses + 1;
    if (config_s) s_pulses <= s_pulses + 1;
    if (config_p) p_pulses <= p_pulses + 1;
    if (mb_wen || mb_ren) last_mb_addr <= mb_addr;
    if (cycles == TIMEOUT_CYCLES) begin
      $display("timeout, tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Something failed");
      $fatal(1, "run stopped by timeout");
    end
  end

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    assert (got === exp) else begin
      $display("error %s got 0x%h expected 0x%h", name, got, exp);
      $display("Something failed");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk);
  endtask

  // One frame, MSB first; bits 9..16 of poci come back in rx
  task automatic spi_frame(input logic [15:0] word, input int nbits,
                           output logic [7:0] rx);
    rx = '0;
    @(posedge clk);
    ncs <= 1'b0;
    wait_cycles(HALF_BIT);
    for (int i = 0; i < nbits; i++) begin
      pico <= word[15-i];
      wait_cycles(HALF_BIT);
      if (i >= 8) rx = {rx[6:0], poci}; // Settled since the last fall
      sck <= 1'b1;
      wait_cycles(HALF_BIT);
      sck <= 1'b0;
    end
    wait_cycles(HALF_BIT);
    ncs <= 1'b1;
    wait_cycles(2 * HALF_BIT); // Write strobe and register update
  endtask

  task automatic spi_write(input logic [3:0] op, input logic [3:0] index,
                           input logic [7:0] data);
    logic [7:0] ignored;
    spi_frame({op, index, data}, 16, ignored);
  endtask

  task automatic spi_read(input logic [3:0] index, output logic [7:0] data);
    spi_frame({OP_MB_READ, index, 8'h00}, 16, data);
  endtask

  task automatic write_snoop_word(input int offset, input logic [31:0] value);
    for (int k = 0; k < 4; k++)
      spi_write(OP_MB_WRITE, 4'(offset + k), value[8*(3-k) +: 8]); // MSB first
  endtask

  task automatic lb_write_byte(input logic [10:0] addr, input logic [7:0] data);
    @(posedge clk);
    lb_addr   <= addr;
    lb_din    <= data;
    lb_write  <= 1'b1;
    lb_strobe <= 1'b1;
    @(posedge clk);
    lb_write  <= 1'b0;
    lb_strobe <= 1'b0;
  endtask

  // Data lands 2 cycles after the strobe, sampled one edge later
  task automatic lb_read_byte(input logic [10:0] addr, output logic [7:0] data);
    @(posedge clk);
    lb_addr   <= addr;
    lb_write  <= 1'b0;
    lb_strobe <= 1'b1;
    @(posedge clk);
    lb_strobe <= 1'b0;
    wait_cycles(2);
    data = lb_dout;
  endtask

  task automatic check_ports();
    for (int s = 0; s < 8; s++) begin
      @(posedge clk);
      pno_a <= 3'(s);
      @(posedge clk);
      check_value("pno_d", 64'(pno_d), 64'(pno_ref[s]));
    end
  endtask

  initial begin
    logic [7:0]  d;
    logic [7:0]  rx;
    logic [7:0]  lo;
    logic [7:0]  hi;
    logic [6:0]  page;
    logic [2:0]  slot;
    logic [31:0] gitid;
    int          count;
    int          frames;
    void'($urandom(63868));
    reset <= 1'b1;
    sck <= 1'b0;
    ncs <= 1'b1;
    pico <= 1'b0;
    lb_addr <= '0;
    lb_din <= '0;
    lb_write <= 1'b0;
    lb_strobe <= 1'b0;
    pno_a <= '0;
    pno_ref[0] = `MAILBOX_UDP_PORT0;
    pno_ref[1] = `MAILBOX_UDP_PORT1;
    pno_ref[2] = `MAILBOX_UDP_PORT2;
    pno_ref[3] = `MAILBOX_UDP_PORT3;
    pno_ref[4] = `MAILBOX_UDP_PORT4;
    pno_ref[5] = `MAILBOX_UDP_PORT5;
    pno_ref[6] = `MAILBOX_UDP_PORT6;
    pno_ref[7] = `MAILBOX_UDP_PORT7;
    wait_cycles(10);
    reset <= 1'b0;
    wait_cycles(2);

    // Reset defaults
    check_value("enable_rx", 64'(enable_rx), 64'(`MAILBOX_DEFAULT_ENABLE_RX));
    check_value("ip_valid", 64'(ip_valid), 64'(0));
    check_value("mac_valid", 64'(mac_valid), 64'(0));
    check_value("mmc_gitid_valid", 64'(mmc_gitid_valid), 64'(0));
    check_value("match", 64'(match), 64'(0));
    check_ports();

    // MAC bytes 5..0 and IP bytes 9..6, MSB highest index
    count = s_pulses;
    frames = wr_pulses;
    for (int i = 0; i < 10; i++) begin
      ipmac_ref[i] = 8'($urandom);
      spi_write(OP_IPMAC, 4'(i), ipmac_ref[i]);
    end
    check_value("config_s", 64'(s_pulses - count), 64'(10));
    check_value("mb_strobe", 64'(wr_pulses - frames), 64'(10));
    check_value("mac", 64'(mac), 64'({ipmac_ref[5], ipmac_ref[4], ipmac_ref[3],
                                      ipmac_ref[2], ipmac_ref[1], ipmac_ref[0]}));
    check_value("ip", 64'(ip), 64'({ipmac_ref[9], ipmac_ref[8], ipmac_ref[7],
                                    ipmac_ref[6]}));
    check_value("mac_valid", 64'(mac_valid), 64'(1));
    check_value("ip_valid", 64'(ip_valid), 64'(1));
    spi_write(OP_IPMAC, 4'd0, ipmac_ref[0]); // Restarts the table
    check_value("mac_valid", 64'(mac_valid), 64'(0));
    check_value("ip_valid", 64'(ip_valid), 64'(0));

    // Receive enable and one port slot
    spi_write(OP_SPECIAL, SPECIAL_ENABLE, 8'h00);
    check_value("enable_rx", 64'(enable_rx), 64'(0));
    spi_write(OP_SPECIAL, SPECIAL_ENABLE, 8'h01);
    check_value("enable_rx", 64'(enable_rx), 64'(1));
    count = p_pulses;
    slot = 3'($urandom_range(0, 7));
    lo = 8'($urandom);
    hi = 8'($urandom);
    spi_write(OP_PORT, {slot, 1'b0}, lo);
    spi_write(OP_PORT, {slot, 1'b1}, hi);
    pno_ref[slot] = {hi, lo};
    check_value("config_p", 64'(p_pulses - count), 64'(2));
    check_ports();

    // Mailbox round trips on pages clear of the snoop pages
    for (int r = 0; r < 3; r++) begin
      page = 7'($urandom_range(5, 127));
      spi_write(OP_SPECIAL, SPECIAL_PAGE, {1'b0, page});
      for (int idx = 0; idx < 6; idx++) begin
        d = 8'($urandom);
        spi_write(OP_MB_WRITE, 4'(idx), d);
        check_value("mb_addr", 64'(last_mb_addr), 64'({page, 4'(idx)}));
        lb_read_byte({page, 4'(idx)}, rx);
        check_value("lb_dout", 64'(rx), 64'(d));
      end
      for (int idx = 6; idx < 12; idx++) begin
        d = 8'($urandom);
        lb_write_byte({page, 4'(idx)}, d);
        spi_read(4'(idx), rx);
        check_value("mb_addr", 64'(last_mb_addr), 64'({page, 4'(idx)}));
        check_value("poci", 64'(rx), 64'(d));
      end
    end

    // Git ID, then a wrong and a right build hash
    gitid = $urandom;
    spi_write(OP_SPECIAL, SPECIAL_PAGE, 8'(`MAILBOX_GITID_PAGE));
    write_snoop_word(`MAILBOX_GITID_OFFSET, gitid);
    check_value("mmc_gitid", 64'(mmc_gitid), 64'(gitid));
    check_value("mmc_gitid_valid", 64'(mmc_gitid_valid), 64'(1));
    spi_write(OP_SPECIAL, SPECIAL_PAGE, 8'(`MAILBOX_HASH_PAGE));
    write_snoop_word(`MAILBOX_HASH_OFFSET, `MAILBOX_HASH ^ 32'h0000_0100);
    check_value("match", 64'(match), 64'(0));
    write_snoop_word(`MAILBOX_HASH_OFFSET, `MAILBOX_HASH);
    check_value("match", 64'(match), 64'(1));

    // Ignored special leaves 0x2 in the low nibble of the shift register
    spi_write(OP_SPECIAL, 4'hf, 8'h02);
    // Twelve zero bits on top would then read as a clear of enable_rx
    count = wr_pulses;
    spi_frame(16'h0000, 12, rx);
    check_value("mb_strobe", 64'(wr_pulses - count), 64'(0));
    check_value("enable_rx", 64'(enable_rx), 64'(1));
    check_value("match", 64'(match), 64'(1));
    check_value("mmc_gitid", 64'(mmc_gitid), 64'(gitid));
    check_value("mac_valid", 64'(mac_valid), 64'(0));
    check_ports();

    $display("Everything OK");
    $finish;
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+hw
hw/mailbox_pkg.sv
hw/spi_responder.sv
hw/mailbox_cmd_decode.sv
hw/mailbox_dpram.sv
hw/mmc_mailbox.sv
test/mailbox_properties.sv
test/tb_mmc_mailbox.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the MMC mailbox testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f vlog.f \
  --top-module tb_mmc_mailbox -Mdir obj_dir -o tb_mmc_mailbox
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_mmc_mailbox > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^Everything OK$" "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1
